/* hdl/pcie_tlp_pkg.sv */
// PCIe user interface types
// Request encodings and the packed structs carried on the CQ, CC, RQ and RC channels

package pcie_tlp_pkg;

    // Request type as seen on CQ and driven on RQ
    typedef enum logic [3:0] {
        REQ_READ  = 4'd0,
        REQ_WRITE = 4'd1
    } tlp_req_e;

    typedef logic [255:0] beat_t;       // One 256-bit data beat

    // Completer request, one MMIO access from the host
    typedef struct packed {
        tlp_req_e    req_type;
        logic [15:0] reg_addr;           // BAR0 offset
        logic [63:0] payload;
        logic [15:0] requester_id;
        logic [7:0]  tag;
        logic [2:0]  tc;
        logic [6:0]  lower_addr;
        logic [10:0] dw_count;
    } mmio_req_t;

    // Completion header returned with read data
    typedef struct packed {
        logic [15:0] requester_id;
        logic [7:0]  tag;
        logic [2:0]  tc;
        logic [6:0]  lower_addr;
        logic [10:0] dword_count;
        logic [2:0]  status;
    } cpl_hdr_t;

    // Outbound requester beat
    typedef struct packed {
        tlp_req_e    req_type;
        logic        sop;
        logic        last;
        logic [63:0] addr;
        logic [10:0] dw_count;           // Whole burst, header not counted
        logic [7:0]  tag;
        logic [2:0]  tc;
        beat_t       payload;
    } rq_req_t;

    // Inbound completion beat, already realigned
    typedef struct packed {
        beat_t payload;
        logic  last;
    } rc_beat_t;

    localparam logic [2:0] CPL_STATUS_SC = 3'd0;   // Successful completion

endpackage

/* hdl/user_regs_pkg.sv */
// BAR0 register map
// Addresses, round-trip modes, transfer sizes and status codes

package user_regs_pkg;

    // ==================================================
    // Register addresses
    localparam logic [15:0] REG_SCRATCH     = 16'h00;
    localparam logic [15:0] REG_ID          = 16'h04;
    localparam logic [15:0] REG_INT_CTRL    = 16'h08;
    localparam logic [15:0] REG_STATUS      = 16'h0C;
    localparam logic [15:0] REG_DMA_ADDR    = 16'h10;   // 64-bit target address
    localparam logic [15:0] REG_DMA_CTRL    = 16'h18;
    localparam logic [15:0] REG_DMA_STATUS  = 16'h1C;
    localparam logic [15:0] REG_RT_SRC_ADDR = 16'h20;
    localparam logic [15:0] REG_RT_DST_ADDR = 16'h28;
    localparam logic [15:0] REG_RT_CTRL     = 16'h30;
    localparam logic [15:0] REG_RT_STATUS   = 16'h34;   // Read only

    // ==================================================
    // Round-trip control
    typedef enum logic [1:0] {
        RT_MODE_OFF   = 2'd0,
        RT_MODE_SMALL = 2'd1,
        RT_MODE_LARGE = 2'd2
    } rt_mode_e;

    localparam logic [10:0] RT_SMALL_DWS   = 11'd4;    // One beat
    localparam logic [10:0] RT_LARGE_DWS   = 11'd12;   // Two beats
    localparam logic [63:0] RT_STATUS_DONE = 64'd2;

endpackage

/* hdl/mmio_reg_file.sv */
// BAR0 register file
// Decodes host writes by address and serves reads through a combinational mux

`timescale 1ns/1ps

module mmio_reg_file (
    input  logic                     user_clk,
    input  logic                     user_reset_p,
    input  logic                     cq_valid,
    input  pcie_tlp_pkg::mmio_req_t  cq_req,
    input  logic [15:0]              rd_addr,
    input  logic                     rt_done,
    output logic [63:0]              rd_data,
    output logic [63:0]              rt_src_addr,
    output logic [63:0]              rt_dst_addr,
    output logic [63:0]              rt_ctrl
);
    import pcie_tlp_pkg::*;
    import user_regs_pkg::*;

    logic [63:0] scratch;
    logic [63:0] id_reg;
    logic [63:0] int_ctrl;
    logic [63:0] status;
    logic [63:0] dma_addr;
    logic [63:0] dma_ctrl;
    logic [63:0] dma_status;
    logic        wr_req;

    assign wr_req = cq_valid && (cq_req.req_type == REQ_WRITE);

    // ==================================================
    // Write decode
    always_ff @(posedge user_clk or posedge user_reset_p) begin
        if (user_reset_p) begin
            scratch     <= '0;
            id_reg      <= '0;
            int_ctrl    <= '0;
            status      <= '0;
            dma_addr    <= '0;
            dma_ctrl    <= '0;
            dma_status  <= '0;
            rt_src_addr <= '0;
            rt_dst_addr <= '0;
            rt_ctrl     <= '0;
        end else if (wr_req) begin
            case (cq_req.reg_addr)
                REG_SCRATCH:     scratch     <= cq_req.payload;
                REG_ID:          id_reg      <= cq_req.payload;
                REG_INT_CTRL:    int_ctrl    <= cq_req.payload;
                REG_STATUS:      status      <= cq_req.payload;
                REG_DMA_ADDR:    dma_addr    <= cq_req.payload;
                REG_DMA_CTRL:    dma_ctrl    <= cq_req.payload;
                REG_DMA_STATUS:  dma_status  <= cq_req.payload;
                REG_RT_SRC_ADDR: rt_src_addr <= cq_req.payload;
                REG_RT_DST_ADDR: rt_dst_addr <= cq_req.payload;
                REG_RT_CTRL:     rt_ctrl     <= cq_req.payload;
                default: ;                  // RT status and holes drop the write
            endcase
        end
    end

    // ==================================================
    // Read mux
    always_comb begin
        case (rd_addr)
            REG_SCRATCH:     rd_data = scratch;
            REG_ID:          rd_data = id_reg;
            REG_INT_CTRL:    rd_data = int_ctrl;
            REG_STATUS:      rd_data = status;
            REG_DMA_ADDR:    rd_data = dma_addr;
            REG_DMA_CTRL:    rd_data = dma_ctrl;
            REG_DMA_STATUS:  rd_data = dma_status;
            REG_RT_SRC_ADDR: rd_data = rt_src_addr;
            REG_RT_DST_ADDR: rd_data = rt_dst_addr;
            REG_RT_CTRL:     rd_data = rt_ctrl;
            REG_RT_STATUS:   rd_data = rt_done ? RT_STATUS_DONE : '0;
            default:         rd_data = '0;      // Unmapped
        endcase
    end

endmodule

/* hdl/cpl_responder.sv */
// Completion responder
// Holds one MMIO read and returns it as a single-beat completion once the host is ready

`timescale 1ns/1ps

module cpl_responder (
    input  logic                     user_clk,
    input  logic                     user_reset_p,
    input  logic                     cq_valid,
    input  pcie_tlp_pkg::mmio_req_t  cq_req,
    input  logic                     cc_ready,
    input  logic [63:0]              rd_data,
    output logic [15:0]              rd_addr,
    output logic                     cc_valid,
    output pcie_tlp_pkg::cpl_hdr_t   cc_hdr,
    output logic [63:0]              cc_data
);
    import pcie_tlp_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_PENDING
    } cc_state_e;

    cc_state_e state;
    cpl_hdr_t  pend_hdr;
    logic      rd_req;
    logic      take_req;
    logic      send_cpl;

    assign rd_req   = cq_valid && (cq_req.req_type == REQ_READ);
    assign take_req = (state == ST_IDLE) && rd_req;
    assign send_cpl = (state == ST_PENDING) && cc_ready;

    always_ff @(posedge user_clk or posedge user_reset_p) begin
        if (user_reset_p) begin
            state    <= ST_IDLE;
            cc_valid <= 1'b0;
        end else begin
            cc_valid <= send_cpl;           // One-cycle strobe
            if (take_req)
                state <= ST_PENDING;
            else if (send_cpl)
                state <= ST_IDLE;
        end
    end

    // Captured request and outgoing completion
    always_ff @(posedge user_clk) begin
        if (take_req) begin
            rd_addr               <= cq_req.reg_addr;
            pend_hdr.requester_id <= cq_req.requester_id;
            pend_hdr.tag          <= cq_req.tag;
            pend_hdr.tc           <= cq_req.tc;
            pend_hdr.lower_addr   <= cq_req.lower_addr;
            pend_hdr.dword_count  <= cq_req.dw_count;
            pend_hdr.status       <= CPL_STATUS_SC;
        end
        if (send_cpl) begin
            cc_hdr  <= pend_hdr;
            cc_data <= rd_data;             // Register value at send time
        end
    end

endmodule

/* hdl/rc_capture_buffer.sv */
// Completion capture buffer
// Stores up to two completion beats for an armed round trip and flags the last one

`timescale 1ns/1ps

module rc_capture_buffer (
    input  logic                     user_clk,
    input  logic                     user_reset_p,
    input  logic                     rc_arm,
    input  logic                     rc_valid,
    input  pcie_tlp_pkg::rc_beat_t   rc,
    output pcie_tlp_pkg::beat_t      beat0,
    output pcie_tlp_pkg::beat_t      beat1,
    output logic                     rc_done
);

    logic slot;         // Next slot to fill
    logic capture;

    // Beats outside an armed trip, or after the last one, fall on the floor
    assign capture = rc_arm && rc_valid && !rc_done;

    always_ff @(posedge user_clk or posedge user_reset_p) begin
        if (user_reset_p) begin
            slot    <= 1'b0;
            rc_done <= 1'b0;
        end else if (!rc_arm) begin
            slot    <= 1'b0;
            rc_done <= 1'b0;
        end else if (capture) begin
            if (rc.last)
                rc_done <= 1'b1;
            else
                slot <= 1'b1;
        end
    end

    // ==================================================
    // Beat storage
    always_ff @(posedge user_clk) begin
        if (capture) begin
            if (!slot)
                beat0 <= rc.payload;
            else
                beat1 <= rc.payload;
        end
    end

endmodule

/* hdl/round_trip_engine.sv */
// Round-trip DMA engine
// Reads 4 or 12 DWs from the source address and writes the same data
// back to the destination address, then reports done

`timescale 1ns/1ps

module round_trip_engine #(
    parameter logic [7:0] rq_read_tag  = 8'd1,
    parameter logic [7:0] rq_write_tag = 8'd2
) (
    input  logic                     user_clk,
    input  logic                     user_reset_p,
    input  logic [63:0]              rt_src_addr,
    input  logic [63:0]              rt_dst_addr,
    input  logic [63:0]              rt_ctrl,
    input  logic                     rc_done,
    input  pcie_tlp_pkg::beat_t      beat0,
    input  pcie_tlp_pkg::beat_t      beat1,
    input  logic                     rq_ready,
    output logic                     rc_arm,
    output logic                     rt_done,
    output logic                     rq_valid,
    output pcie_tlp_pkg::rq_req_t    rq
);
    import pcie_tlp_pkg::*;
    import user_regs_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND_READ,
        ST_WAIT_DATA,
        ST_SEND_WRITE,
        ST_DONE
    } rt_state_e;

    rt_state_e state;
    rt_mode_e  mode;            // Latched at trip start
    rt_mode_e  start_mode;
    logic      start_req;
    logic      rq_accept;
    logic      load_read;
    logic      load_wr0;
    logic      load_wr1;

    function automatic logic [10:0] dws_for(input rt_mode_e m);
        return (m == RT_MODE_LARGE) ? RT_LARGE_DWS : RT_SMALL_DWS;
    endfunction

    assign start_mode = rt_mode_e'(rt_ctrl[1:0]);
    assign start_req  = (rt_ctrl == 64'(RT_MODE_SMALL)) || (rt_ctrl == 64'(RT_MODE_LARGE));
    assign rq_accept  = rq_valid && rq_ready;

    assign load_read = (state == ST_IDLE) && start_req;
    assign load_wr0  = (state == ST_WAIT_DATA) && rc_done;
    assign load_wr1  = (state == ST_SEND_WRITE) && rq_accept && !rq.last;

    // ==================================================
    // Trip FSM
    always_ff @(posedge user_clk or posedge user_reset_p) begin
        if (user_reset_p) begin
            state    <= ST_IDLE;
            mode     <= RT_MODE_OFF;
            rq_valid <= 1'b0;
            rc_arm   <= 1'b0;
            rt_done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_req) begin
                        mode     <= start_mode;
                        rc_arm   <= 1'b1;       // Open the buffer before the read goes out
                        rq_valid <= 1'b1;
                        state    <= ST_SEND_READ;
                    end
                end
                ST_SEND_READ: begin
                    if (rq_accept) begin
                        rq_valid <= 1'b0;
                        state    <= ST_WAIT_DATA;
                    end
                end
                ST_WAIT_DATA: begin
                    if (rc_done) begin
                        rq_valid <= 1'b1;
                        state    <= ST_SEND_WRITE;
                    end
                end
                ST_SEND_WRITE: begin
                    if (rq_accept && rq.last) begin
                        rq_valid <= 1'b0;
                        rt_done  <= 1'b1;
                        state    <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (rt_ctrl == 64'(RT_MODE_OFF)) begin   // Host acknowledges
                        rt_done <= 1'b0;
                        rc_arm  <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request beat, held steady under back-pressure
    always_ff @(posedge user_clk) begin
        if (load_read) begin
            rq.req_type <= REQ_READ;
            rq.sop      <= 1'b1;
            rq.last     <= 1'b1;
            rq.addr     <= rt_src_addr;
            rq.dw_count <= dws_for(start_mode);
            rq.tag      <= rq_read_tag;
            rq.tc       <= 3'd0;
            rq.payload  <= '0;
        end else if (load_wr0) begin
            rq.req_type <= REQ_WRITE;
            rq.sop      <= 1'b1;
            rq.last     <= (mode == RT_MODE_SMALL);   // Small trip fits one beat
            rq.addr     <= rt_dst_addr;
            rq.dw_count <= dws_for(mode);
            rq.tag      <= rq_write_tag;
            rq.tc       <= 3'd0;
            rq.payload  <= beat0;
        end else if (load_wr1) begin
            rq.sop     <= 1'b0;                       // Second beat of a large trip
            rq.last    <= 1'b1;
            rq.payload <= beat1;
        end
    end

endmodule

/* hdl/user_logic.sv */
// PCIe endpoint user logic
// Register file, completion responder, round-trip engine and
// completion capture buffer around the four user channels

`timescale 1ns/1ps

module user_logic (
    input  logic                     user_clk,
    input  logic                     user_reset_p,
    // Host MMIO requests
    input  logic                     cq_valid,
    input  pcie_tlp_pkg::mmio_req_t  cq_req,
    // Read completions to the host
    input  logic                     cc_ready,
    output logic                     cc_valid,
    output pcie_tlp_pkg::cpl_hdr_t   cc_hdr,
    output logic [63:0]              cc_data,
    // DMA requests to the host
    input  logic                     rq_ready,
    output logic                     rq_valid,
    output pcie_tlp_pkg::rq_req_t    rq,
    // DMA read completions from the host
    input  logic                     rc_valid,
    input  pcie_tlp_pkg::rc_beat_t   rc
);
    import pcie_tlp_pkg::*;

    logic [15:0] rd_addr;
    logic [63:0] rd_data;
    logic [63:0] rt_src_addr;
    logic [63:0] rt_dst_addr;
    logic [63:0] rt_ctrl;
    logic        rt_done;
    logic        rc_arm;
    logic        rc_done;
    beat_t       beat0;
    beat_t       beat1;

    // ==================================================
    // MMIO side
    mmio_reg_file mmio_reg_file_inst (
        .user_clk     (user_clk),
        .user_reset_p (user_reset_p),
        .cq_valid     (cq_valid),
        .cq_req       (cq_req),
        .rd_addr      (rd_addr),
        .rt_done      (rt_done),
        .rd_data      (rd_data),
        .rt_src_addr  (rt_src_addr),
        .rt_dst_addr  (rt_dst_addr),
        .rt_ctrl      (rt_ctrl)
    );

    cpl_responder cpl_responder_inst (
        .user_clk     (user_clk),
        .user_reset_p (user_reset_p),
        .cq_valid     (cq_valid),
        .cq_req       (cq_req),
        .cc_ready     (cc_ready),
        .rd_data      (rd_data),
        .rd_addr      (rd_addr),
        .cc_valid     (cc_valid),
        .cc_hdr       (cc_hdr),
        .cc_data      (cc_data)
    );

    // ==================================================
    // DMA side
    round_trip_engine #(
        .rq_read_tag  (8'd1),
        .rq_write_tag (8'd2)
    ) round_trip_engine_inst (
        .user_clk     (user_clk),
        .user_reset_p (user_reset_p),
        .rt_src_addr  (rt_src_addr),
        .rt_dst_addr  (rt_dst_addr),
        .rt_ctrl      (rt_ctrl),
        .rc_done      (rc_done),
        .beat0        (beat0),
        .beat1        (beat1),
        .rq_ready     (rq_ready),
        .rc_arm       (rc_arm),
        .rt_done      (rt_done),
        .rq_valid     (rq_valid),
        .rq           (rq)
    );

    rc_capture_buffer rc_capture_buffer_inst (
        .user_clk     (user_clk),
        .user_reset_p (user_reset_p),
        .rc_arm       (rc_arm),
        .rc_valid     (rc_valid),
        .rc           (rc),
        .beat0        (beat0),
        .beat1        (beat1),
        .rc_done      (rc_done)
    );

endmodule

/* tb/tb_user_logic.sv */
// Testbench for the PCIe endpoint user logic
// Directed tests for MMIO access, completion back-pressure and round trips

`timescale 1ns/1ps

module tb_user_logic;
    import pcie_tlp_pkg::*;
    import user_regs_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int STATUS_POLLS   = 50;

    logic        user_clk;
    logic        user_reset_p;
    logic        cq_valid;
    mmio_req_t   cq_req;
    logic        cc_ready;
    logic        cc_valid;
    cpl_hdr_t    cc_hdr;
    logic [63:0] cc_data;
    logic        rq_ready;
    logic        rq_valid;
    rq_req_t     rq;
    logic        rc_valid;
    rc_beat_t    rc;

    int          errors;
    int          timeouts;
    mmio_req_t   last_rd;           // Read currently in flight

    user_logic user_logic_inst (
        .user_clk     (user_clk),
        .user_reset_p (user_reset_p),
        .cq_valid     (cq_valid),
        .cq_req       (cq_req),
        .cc_ready     (cc_ready),
        .cc_valid     (cc_valid),
        .cc_hdr       (cc_hdr),
        .cc_data      (cc_data),
        .rq_ready     (rq_ready),
        .rq_valid     (rq_valid),
        .rq           (rq),
        .rc_valid     (rc_valid),
        .rc           (rc)
    );

    initial begin
        user_clk = 1'b0;
        forever #20 user_clk = ~user_clk;
    end

    // ==================================================
    // Host-side helpers
    task automatic report_mismatch(input string test, input logic [511:0] exp,
                                   input logic [511:0] act);
        $display("ERROR %s: expected %0h, actual %0h", test, exp, act);
        errors++;
    endtask

    function automatic beat_t rand_beat();
        beat_t b;
        int    i;
        for (i = 0; i < 8; i++)
            b[i*32 +: 32] = $urandom;
        return b;
    endfunction

    // Traffic class is not compared and read payload carries nothing
    function automatic logic rq_matches(input rq_req_t exp, input rq_req_t act);
        rq_req_t a;
        a    = act;
        a.tc = exp.tc;
        if (exp.req_type == REQ_READ)
            a.payload = exp.payload;
        return (a === exp);
    endfunction

    task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
        mmio_req_t req;
        req          = '0;
        req.req_type = REQ_WRITE;
        req.reg_addr = addr;
        req.payload  = data;
        req.dw_count = 11'd2;
        @(posedge user_clk);
        cq_valid <= 1'b1;
        cq_req   <= req;
        @(posedge user_clk);
        cq_valid <= 1'b0;
    endtask

    task automatic issue_read(input logic [15:0] addr);
        last_rd              = '0;
        last_rd.req_type     = REQ_READ;
        last_rd.reg_addr     = addr;
        last_rd.requester_id = 16'($urandom);
        last_rd.tag          = 8'($urandom);
        last_rd.tc           = 3'($urandom);
        last_rd.lower_addr   = 7'(addr);
        last_rd.dw_count     = 11'($urandom_range(1, 2));
        @(posedge user_clk);
        cq_valid <= 1'b1;
        cq_req   <= last_rd;
        @(posedge user_clk);
        cq_valid <= 1'b0;
    endtask

    // Completion must echo the request header with status 0
    task automatic collect_cpl(input string test, output logic [63:0] data);
        cpl_hdr_t exp_hdr;
        int       n;
        n    = 0;
        data = '0;
        exp_hdr.requester_id = last_rd.requester_id;
        exp_hdr.tag          = last_rd.tag;
        exp_hdr.tc           = last_rd.tc;
        exp_hdr.lower_addr   = last_rd.lower_addr;
        exp_hdr.dword_count  = last_rd.dw_count;
        exp_hdr.status       = 3'd0;
        @(negedge user_clk);
        while (!cc_valid && n < TIMEOUT_CYCLES) begin
            @(negedge user_clk);
            n++;
        end
        if (!cc_valid) begin
            $display("%s: timed out waiting for a read completion", test);
            timeouts++;
        end else begin
            data = cc_data;
            if (cc_hdr !== exp_hdr)
                report_mismatch({test, " header"}, 512'(exp_hdr), 512'(cc_hdr));
        end
    endtask

    task automatic mmio_read(input string test, input logic [15:0] addr,
                             output logic [63:0] data);
        issue_read(addr);
        collect_cpl(test, data);
    endtask

    // Random stalls on rq_ready until one beat is taken
    task automatic host_accept_rq(input string test, output rq_req_t beat);
        int n;
        bit got;
        n    = 0;
        got  = 1'b0;
        beat = '0;
        while (!got && n < TIMEOUT_CYCLES) begin
            @(posedge user_clk);
            rq_ready <= ($urandom_range(0, 3) != 0);
            @(negedge user_clk);
            if (rq_valid && rq_ready) begin
                beat = rq;
                got  = 1'b1;
            end
            n++;
        end
        @(posedge user_clk);                // Beat taken on this edge
        rq_ready <= 1'b0;
        if (!got) begin
            $display("%s: timed out waiting for a request beat", test);
            timeouts++;
        end
    endtask

    task automatic host_send_rc(input beat_t data, input logic last);
        @(posedge user_clk);
        rc_valid   <= 1'b1;
        rc.payload <= data;
        rc.last    <= last;
        @(posedge user_clk);
        rc_valid <= 1'b0;
    endtask

    // Poll for done, then acknowledge and expect status to clear
    task automatic finish_trip(input string test);
        logic [63:0] got;
        int          n;
        n   = 0;
        got = '0;
        while (got !== 64'd2 && n < STATUS_POLLS) begin
            mmio_read(test, REG_RT_STATUS, got);
            n++;
        end
        if (got !== 64'd2) begin
            $display("%s: round trip never reported done", test);
            timeouts++;
        end
        mmio_write(REG_RT_CTRL, 64'd0);
        mmio_read(test, REG_RT_STATUS, got);
        if (got !== 64'd0)
            report_mismatch({test, " status clear"}, 512'(64'd0), 512'(got));
    endtask

    // ==================================================
    // Directed tests
    task automatic test_reg_readback();
        logic [15:0] addrs [10];
        logic [63:0] vals [10];
        logic [63:0] got;
        int          i;
        addrs = '{REG_SCRATCH, REG_ID, REG_INT_CTRL, REG_STATUS, REG_DMA_ADDR,
                  REG_DMA_CTRL, REG_DMA_STATUS, REG_RT_SRC_ADDR, REG_RT_DST_ADDR,
                  REG_RT_CTRL};
        for (i = 0; i < 10; i++) begin
            vals[i] = {$urandom, $urandom};
            if (addrs[i] == REG_RT_CTRL)
                vals[i][63] = 1'b1;         // Never a start value
            mmio_write(addrs[i], vals[i]);
        end
        for (i = 0; i < 10; i++) begin
            mmio_read("reg_readback", addrs[i], got);
            if (got !== vals[i])
                report_mismatch("reg_readback", 512'(vals[i]), 512'(got));
        end
        mmio_write(REG_RT_CTRL, 64'd0);
    endtask

    task automatic test_unmapped();
        logic [15:0] holes [4];
        logic [63:0] got;
        int          i;
        holes = '{16'h0014, 16'h0038, 16'h0100, 16'hFFF8};
        for (i = 0; i < 4; i++) begin
            mmio_write(holes[i], {$urandom, $urandom});
            mmio_read("unmapped", holes[i], got);
            if (got !== 64'd0)
                report_mismatch("unmapped", 512'(64'd0), 512'(got));
        end
        mmio_write(REG_RT_STATUS, 64'd2);
        mmio_read("rt_status_write", REG_RT_STATUS, got);
        if (got !== 64'd0)
            report_mismatch("rt_status_write", 512'(64'd0), 512'(got));
    endtask

    task automatic test_cc_backpressure();
        logic [63:0] val;
        logic [63:0] got;
        int          i;
        int          extra;
        val = {$urandom, $urandom};
        mmio_write(REG_SCRATCH, val);
        @(posedge user_clk);
        cc_ready <= 1'b0;
        issue_read(REG_SCRATCH);
        for (i = 0; i < 8; i++) begin
            @(negedge user_clk);
            if (cc_valid) begin
                $display("cc_backpressure: completion sent while cc_ready was low");
                errors++;
            end
        end
        @(posedge user_clk);
        cc_ready <= 1'b1;
        collect_cpl("cc_backpressure", got);
        if (got !== val)
            report_mismatch("cc_backpressure", 512'(val), 512'(got));
        extra = 0;
        for (i = 0; i < 6; i++) begin
            @(negedge user_clk);
            if (cc_valid)
                extra++;
        end
        if (extra != 0) begin
            $display("cc_backpressure: %0d extra completion cycles after the first", extra);
            errors++;
        end
    endtask

    task automatic test_small_trip();
        logic [63:0] src;
        logic [63:0] dst;
        rq_req_t     beat;
        rq_req_t     exp;
        beat_t       data;
        src = {$urandom, $urandom};
        dst = {$urandom, $urandom};
        mmio_write(REG_RT_SRC_ADDR, src);
        mmio_write(REG_RT_DST_ADDR, dst);
        mmio_write(REG_RT_CTRL, 64'd1);
        exp          = '0;
        exp.req_type = REQ_READ;
        exp.sop      = 1'b1;
        exp.last     = 1'b1;
        exp.addr     = src;
        exp.dw_count = 11'd4;
        exp.tag      = 8'd1;
        host_accept_rq("small_trip read", beat);
        if (!rq_matches(exp, beat))
            report_mismatch("small_trip read", 512'(exp), 512'(beat));
        data = rand_beat();
        host_send_rc(data, 1'b1);
        exp.req_type = REQ_WRITE;           // Same beat shape now carries data
        exp.addr     = dst;
        exp.tag      = 8'd2;
        exp.payload  = data;
        host_accept_rq("small_trip write", beat);
        if (!rq_matches(exp, beat))
            report_mismatch("small_trip write", 512'(exp), 512'(beat));
        finish_trip("small_trip");
    endtask

    task automatic test_large_trip();
        logic [63:0] src;
        logic [63:0] dst;
        rq_req_t     beat;
        rq_req_t     exp;
        beat_t       d0;
        beat_t       d1;
        src = {$urandom, $urandom};
        dst = {$urandom, $urandom};
        mmio_write(REG_RT_SRC_ADDR, src);
        mmio_write(REG_RT_DST_ADDR, dst);
        mmio_write(REG_RT_CTRL, 64'd2);
        exp          = '0;
        exp.req_type = REQ_READ;
        exp.sop      = 1'b1;
        exp.last     = 1'b1;
        exp.addr     = src;
        exp.dw_count = 11'd12;
        exp.tag      = 8'd1;
        host_accept_rq("large_trip read", beat);
        if (!rq_matches(exp, beat))
            report_mismatch("large_trip read", 512'(exp), 512'(beat));
        d0 = rand_beat();
        d1 = rand_beat();
        host_send_rc(d0, 1'b0);
        host_send_rc(d1, 1'b1);
        exp.req_type = REQ_WRITE;
        exp.last     = 1'b0;
        exp.addr     = dst;
        exp.tag      = 8'd2;
        exp.payload  = d0;
        host_accept_rq("large_trip write0", beat);
        if (!rq_matches(exp, beat))
            report_mismatch("large_trip write0", 512'(exp), 512'(beat));
        exp.sop     = 1'b0;
        exp.last    = 1'b1;
        exp.payload = d1;
        host_accept_rq("large_trip write1", beat);
        if (!rq_matches(exp, beat))
            report_mismatch("large_trip write1", 512'(exp), 512'(beat));
        finish_trip("large_trip");
    endtask

    // ==================================================
    // Main sequence
    initial begin
        void'($urandom(32'h8784_4ee6));
        errors       = 0;
        timeouts     = 0;
        user_reset_p = 1'b1;
        cq_valid     = 1'b0;
        cq_req       = '0;
        cc_ready     = 1'b1;
        rq_ready     = 1'b0;
        rc_valid     = 1'b0;
        rc           = '0;
        repeat (8) @(posedge user_clk);
        user_reset_p <= 1'b0;
        @(posedge user_clk);

        test_reg_readback();
        test_unmapped();
        test_cc_backpressure();
        test_small_trip();
        test_large_trip();

        repeat (4) @(posedge user_clk);
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* user_logic.f */
hdl/pcie_tlp_pkg.sv
hdl/user_regs_pkg.sv
hdl/mmio_reg_file.sv
hdl/cpl_responder.sv
hdl/rc_capture_buffer.sv
hdl/round_trip_engine.sv
hdl/user_logic.sv
tb/tb_user_logic.sv

/* run_sim.sh */
#!/bin/sh
# Build the user logic testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_user_logic \
    -f user_logic.f \
    -o sim_tb_user_logic

out=$(./obj_dir/sim_tb_user_logic)
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
